// File: project.f
common/uart_bank_pkg.sv
uart_tx/uart_tx_channel.sv
src/tx_dispatch.sv
src/tx_done_collect.sv
src/uart_tx_bank.sv
bench/uart_rx_model.sv
bench/tb_uart_tx_bank.sv

// File: bench/tb_uart_tx_bank.sv
// testbench for the uart transmit bank with four channels at eight clocks per bit
// host writes go out on the falling edge and a receiver per line checks each frame
`timescale 1ns/1ps

module tb_uart_tx_bank;

  localparam int NUM_CHAN      = 4;
  localparam int CHAN_W        = $clog2(NUM_CHAN);
  localparam int CLK_FREQ_HZ   = 1_000_000;
  localparam int BAUD_RATE     = 125_000;
  localparam int BIT_TIME      = CLK_FREQ_HZ / BAUD_RATE;  // 8 cycles
  localparam int CLK_PERIOD    = 8;
  localparam int RAND_FRAMES   = 6;  // per channel in the concurrent test
  localparam int B2B_FRAMES    = 4;
  localparam int TOTAL_FRAMES  = 2 + NUM_CHAN + NUM_CHAN * RAND_FRAMES + B2B_FRAMES;
  localparam int MARGIN_CYCLES = 500;
  localparam int WATCHDOG_NS   = (TOTAL_FRAMES * 10 * BIT_TIME + MARGIN_CYCLES) * CLK_PERIOD;

  logic                 clk;
  logic                 rst_n;
  logic                 wr;
  logic [CHAN_W-1:0]    wr_chan;
  uart_bank_pkg::byte_t wr_data;
  logic [NUM_CHAN-1:0]  full;
  logic [NUM_CHAN-1:0]  tx;
  logic                 done;
  logic [CHAN_W-1:0]    done_chan;

  logic [NUM_CHAN-1:0]  got;        // receiver strobes
  logic [NUM_CHAN-1:0]  frame_err;
  logic [NUM_CHAN-1:0]  width_err;
  logic [9:0]           rx_frame [NUM_CHAN];

  logic [9:0] exp_q [NUM_CHAN][$];  // expected frames in write order
  int         exp_done [NUM_CHAN];
  int         done_cnt [NUM_CHAN];
  int         rx_cnt [NUM_CHAN];
  int         accepted;
  int         dones;
  int         data_errs;
  int         line_errs;
  int         done_errs;
  int         flow_errs;
  int         solo_chan;  // >= 0 while only that line may toggle
  integer     seed;

  uart_tx_bank #(
    .NUM_CHAN    (NUM_CHAN),
    .CLK_FREQ_HZ (CLK_FREQ_HZ),
    .BAUD_RATE   (BAUD_RATE)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr        (wr),
    .wr_chan   (wr_chan),
    .wr_data   (wr_data),
    .full      (full),
    .tx        (tx),
    .done      (done),
    .done_chan (done_chan)
  );

  for (genvar i = 0; i < NUM_CHAN; i++) begin : g_rx
    uart_rx_model #(
      .BIT_TIME (BIT_TIME)
    ) i_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .line      (tx[i]),
      .got       (got[i]),
      .frame     (rx_frame[i]),
      .frame_err (frame_err[i]),
      .width_err (width_err[i])
    );
  end

  // expected 8n1 frame on the line with index 0 sent first
  function automatic logic [9:0] expected_frame(input logic [7:0] b);
    logic [9:0] f;
    f[0] = 1'b0;  // start
    for (int k = 0; k < 8; k++) begin
      f[k+1] = b[k];  // lsb first
    end
    f[9] = 1'b1;  // stop
    return f;
  endfunction

  // called on a falling edge so the bank samples the write at the next rise
  task automatic put_write(input int ch, input logic [7:0] b, output bit taken);
    wr      = 1'b1;
    wr_chan = CHAN_W'(ch);
    wr_data = b;
    taken   = !full[ch];  // full only moves on the rising edge
    if (taken) begin
      exp_q[ch].push_back(expected_frame(b));
      exp_done[ch]++;
      accepted++;
    end
  endtask

  // idle the host port until every frame and done has come back
  task automatic wait_drain();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      wr   = 1'b0;
      busy = 1'b0;
      for (int i = 0; i < NUM_CHAN; i++) begin
        if (exp_q[i].size() != 0 || done_cnt[i] < exp_done[i] || full[i])
          busy = 1'b1;
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired with frames or done strobes still outstanding");
    $display("Result: FAILED");
    $finish;
  end

  // scoreboard sampling receiver and done outputs at the rising edge
  always @(posedge clk) begin
    logic [9:0] exp_frame;
    if (rst_n) begin
      for (int i = 0; i < NUM_CHAN; i++) begin
        if (got[i]) begin
          rx_cnt[i]++;
          assert (!frame_err[i]) else begin
            $display("framing fault on channel %0d at %0t", i, $time);
            line_errs++;
          end
          assert (!width_err[i]) else begin
            $display("a bit on channel %0d did not last %0d cycles", i, BIT_TIME);
            line_errs++;
          end
          assert (exp_q[i].size() > 0) else begin
            $display("unexpected byte %h on channel %0d", rx_frame[i][8:1], i);
            data_errs++;
          end
          if (exp_q[i].size() > 0) begin
            exp_frame = exp_q[i].pop_front();
            assert (rx_frame[i] == exp_frame) else begin
              $display("ERROR %0t: channel %0d frame %b, expected %b",
                       $time, i, rx_frame[i], exp_frame);
              data_errs++;
            end
          end
        end
        if (solo_chan >= 0 && i != solo_chan) begin
          assert (tx[i] === 1'b1) else begin
            $display("ERROR %0t: line %0d left idle during the single frame", $time, i);
            line_errs++;
          end
        end
      end
      if (done) begin
        dones++;
        // done must follow the frame that the receiver already saw
        assert (rx_cnt[done_chan] > done_cnt[done_chan]) else begin
          $display("done on channel %0d at %0t without a finished frame", done_chan, $time);
          done_errs++;
        end
        done_cnt[done_chan]++;
      end
    end
  end

  initial begin
    bit taken;
    int left [NUM_CHAN];
    int start;
    int pick;
    int idx;
    bit more;
    seed      = 32'h2fac;
    rst_n     = 1'b0;
    wr        = 1'b0;
    wr_chan   = '0;
    wr_data   = '0;
    solo_chan = -1;
    repeat (4) @(negedge clk);  // four rising edges in reset
    rst_n = 1'b1;

    // state straight after reset
    @(negedge clk);
    assert (tx === '1 && full === '0 && done === 1'b0) else begin
      $display("ERROR %0t: after reset tx %b full %b done %b", $time, tx, full, done);
      data_errs++;
    end

    // one frame alone on channel 1
    solo_chan = 1;
    put_write(1, 8'ha5, taken);
    assert (taken) else begin
      $display("write to idle channel 1 was refused");
      flow_errs++;
    end
    wait_drain();
    solo_chan = -1;

    // second write while the slot is held gets dropped
    @(negedge clk);
    put_write(2, 8'h3c, taken);
    @(negedge clk);
    put_write(2, 8'hc3, taken);
    assert (!taken) else begin
      $display("full did not rise after the write to channel 2");
      flow_errs++;
    end
    wait_drain();

    // burst of writes in back-to-back cycles to every channel
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      @(negedge clk);
      put_write(ch, 8'($random(seed)), taken);
      assert (taken) else begin
        $display("burst write to idle channel %0d was refused", ch);
        flow_errs++;
      end
    end
    wait_drain();

    // random traffic with each channel refilled as soon as it frees up
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      left[ch] = RAND_FRAMES;
    end
    more = 1'b1;
    while (more) begin
      @(negedge clk);
      start = $unsigned($random(seed)) % NUM_CHAN;
      pick  = -1;
      for (int k = 0; k < NUM_CHAN; k++) begin
        idx = (start + k) % NUM_CHAN;
        if (pick < 0 && left[idx] > 0 && !full[idx])
          pick = idx;
      end
      if (pick >= 0) begin
        put_write(pick, 8'($random(seed)), taken);
        left[pick]--;
      end else if (full[start]) begin
        put_write(start, 8'($random(seed)), taken);  // lands on a busy slot
      end else begin
        wr = 1'b0;
      end
      more = 1'b0;
      for (int k = 0; k < NUM_CHAN; k++) begin
        if (left[k] > 0)
          more = 1'b1;
      end
    end
    wait_drain();

    // channel 3 refilled the moment full falls
    for (int n = 0; n < B2B_FRAMES; n++) begin
      do begin
        @(negedge clk);
        wr = 1'b0;
      end while (full[3]);
      put_write(3, 8'($random(seed)), taken);
      @(negedge clk);
      wr = 1'b0;
      assert (full[3]) else begin
        $display("full on channel 3 did not rise after write %0d", n);
        flow_errs++;
      end
    end
    wait_drain();

    repeat (20) @(negedge clk);  // room for any stray done
    for (int ch = 0; ch < NUM_CHAN; ch++) begin
      assert (done_cnt[ch] == exp_done[ch]) else begin
        $display("channel %0d gave %0d done strobes for %0d frames",
                 ch, done_cnt[ch], exp_done[ch]);
        done_errs++;
      end
    end
    assert (dones == accepted && accepted == TOTAL_FRAMES) else begin
      $display("%0d done strobes, %0d writes accepted, %0d planned",
               dones, accepted, TOTAL_FRAMES);
      done_errs++;
    end

    $display("errors: data %0d, line %0d, done %0d, flow %0d",
             data_errs, line_errs, done_errs, flow_errs);
    if (data_errs + line_errs + done_errs + flow_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: bench/uart_rx_model.sv
// behavioral 8n1 receiver for one serial line, used by the bank testbench
// samples every bit at mid-bit and flags bad start/stop levels or uneven bit lengths
`timescale 1ns/1ps

module uart_rx_model #(
  parameter int BIT_TIME = 8  // clk cycles per serial bit
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       line,       // serial input, idle high
  output logic       got,        // one-cycle strobe per received frame
  output logic [9:0] frame,      // sampled bits, start bit at index 0
  output logic       frame_err,  // start not 0 or stop not 1, valid with got
  output logic       width_err   // some bit not held for BIT_TIME cycles
);

  localparam int MID = BIT_TIME / 2;

  logic [9:0] bits;    // mid-bit samples of the frame in progress
  logic       level;   // level seen in the first cycle of a bit
  logic       uneven;
  logic       v;

  // line is read right at the rising edge, so every sample is the value
  // the transmitter held through the previous cycle
  always begin
    @(posedge clk);
    got <= 1'b0;
    if (rst_n && line === 1'b0) begin
      // this edge is the first cycle of the start bit
      uneven = 1'b0;
      bits   = '0;
      level  = 1'b0;
      for (int b = 0; b < 10; b++) begin
        for (int c = 0; c < BIT_TIME; c++) begin
          if (b != 0 || c != 0) begin
            @(posedge clk);
          end
          v = line;
          if (c == 0) begin
            level = v;  // reference for the rest of this bit
          end else if (v !== level) begin
            uneven = 1'b1;  // edge inside a bit slot
          end
          if (c == MID) begin
            bits[b] = v;
          end
        end
      end
      frame     <= bits;
      frame_err <= (bits[0] !== 1'b0) || (bits[9] !== 1'b1);
      width_err <= uneven;
      got       <= 1'b1;
    end
  end

endmodule

// File: src/uart_tx_bank.sv
// multi-channel uart transmit bank, the top level
// host writes bytes per channel, each channel drives its own 8n1 line
`timescale 1ns/1ps

module uart_tx_bank #(
  parameter int NUM_CHAN    = 4,
  parameter int CLK_FREQ_HZ = 50_000_000,
  parameter int BAUD_RATE   = 115_200
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr,
  input  logic [CHAN_W-1:0]    wr_chan,
  input  uart_bank_pkg::byte_t wr_data,
  output logic [NUM_CHAN-1:0]  full,       // per-channel back-pressure
  output logic [NUM_CHAN-1:0]  tx,         // serial lines, idle high
  output logic                 done,       // end of a frame
  output logic [CHAN_W-1:0]    done_chan
);

  localparam int CHAN_W   = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;
  localparam int BIT_TIME = CLK_FREQ_HZ / BAUD_RATE;  // clk cycles per bit

  logic [NUM_CHAN-1:0]                 go;
  logic [NUM_CHAN-1:0]                 bsy;
  uart_bank_pkg::byte_t [NUM_CHAN-1:0] data;

  tx_dispatch #(
    .NUM_CHAN (NUM_CHAN)
  ) i_dispatch (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr),
    .wr_chan (wr_chan),
    .wr_data (wr_data),
    .bsy     (bsy),
    .full    (full),
    .go      (go),
    .data    (data)
  );

  // identical transmitters, one per line
  for (genvar i = 0; i < NUM_CHAN; i++) begin : g_tx
    uart_tx_channel #(
      .BIT_TIME (BIT_TIME)
    ) i_tx (
      .clk   (clk),
      .rst_n (rst_n),
      .data  (data[i]),
      .go    (go[i]),
      .tx    (tx[i]),
      .bsy   (bsy[i])
    );
  end

  tx_done_collect #(
    .NUM_CHAN (NUM_CHAN)
  ) i_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .bsy       (bsy),
    .done      (done),
    .done_chan (done_chan)
  );

endmodule

// File: src/tx_done_collect.sv
// turns the end of every frame into a done strobe with its channel number
// completions in the same cycle are queued and reported round-robin
`timescale 1ns/1ps

module tx_done_collect #(
  parameter int NUM_CHAN = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [NUM_CHAN-1:0] bsy,
  output logic                done,      // one-cycle completion strobe
  output logic [CHAN_W-1:0]   done_chan  // valid with done
);

  localparam int CHAN_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

  logic [NUM_CHAN-1:0] bsy_q;    // bsy one cycle back
  logic [NUM_CHAN-1:0] fall;     // bsy just dropped
  logic [NUM_CHAN-1:0] pending;  // finished, not reported yet
  logic [NUM_CHAN-1:0] req;
  logic [NUM_CHAN-1:0] grant;    // one-hot of the reported channel
  logic [CHAN_W-1:0]   last;     // channel reported most recently
  logic [CHAN_W-1:0]   sel;
  logic                found;

  assign fall = bsy_q & ~bsy;
  assign req  = pending | fall;  // a fresh fall can go out right away

  // search starts one past the last reported channel
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = '0;
    grant = '0;
    for (int k = 1; k <= NUM_CHAN; k++) begin
      idx = (int'(last) + k) % NUM_CHAN;
      if (!found && req[idx]) begin
        found      = 1'b1;
        sel        = CHAN_W'(idx);
        grant[idx] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bsy_q     <= '0;
      pending   <= '0;
      last      <= CHAN_W'(NUM_CHAN - 1);  // first search begins at channel 0
      done      <= 1'b0;
      done_chan <= '0;
    end else begin
      bsy_q   <= bsy;
      pending <= req & ~grant;
      done    <= found;
      if (found) begin
        done_chan <= sel;
        last      <= sel;
      end
    end
  end

  // a frame takes far longer than a full round-robin sweep,
  // so a second fall on a still pending channel is a lost completion
  a_no_lost_done: assert property (
    @(posedge clk) disable iff (!rst_n)
    (fall & pending) == '0
  );

endmodule

// File: src/tx_dispatch.sv
// host write port of the bank, one byte holding slot per channel
// drives go/data to each transmitter and releases the slot after the frame
`timescale 1ns/1ps

module tx_dispatch #(
  parameter int NUM_CHAN = 4
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                wr,       // one-cycle write strobe
  input  logic [CHAN_W-1:0]                   wr_chan,  // valid with wr
  input  uart_bank_pkg::byte_t                wr_data,  // valid with wr
  input  logic [NUM_CHAN-1:0]                 bsy,
  output logic [NUM_CHAN-1:0]                 full,     // slot taken, writes dropped
  output logic [NUM_CHAN-1:0]                 go,
  output uart_bank_pkg::byte_t [NUM_CHAN-1:0] data
);

  localparam int CHAN_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

  // slot life cycle per channel
  typedef enum logic [1:0] {
    ph_empty,      // free for a host write
    ph_wait_rise,  // go asserted, channel not started yet
    ph_wait_fall   // frame on the line
  } phase_e;

  phase_e               phase [NUM_CHAN];
  uart_bank_pkg::byte_t slot  [NUM_CHAN];
  logic [NUM_CHAN-1:0]  take;  // accepted write per channel

  for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
    assign take[i] = wr && (wr_chan == CHAN_W'(i)) && !full[i];
    assign full[i] = (phase[i] != ph_empty);  // rises the cycle after the write
    assign data[i] = slot[i];

    // payload register, only loaded while the slot is empty
    always_ff @(posedge clk) begin
      if (take[i]) begin
        slot[i] <= wr_data;
      end
    end

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        phase[i] <= ph_empty;
        go[i]    <= 1'b0;
      end else begin
        case (phase[i])
          ph_empty: begin
            if (take[i]) begin
              phase[i] <= ph_wait_rise;
            end
          end

          ph_wait_rise: begin
            go[i] <= 1'b1;  // one cycle after full
            if (bsy[i]) begin
              phase[i] <= ph_wait_fall;
            end
          end

          ph_wait_fall: begin
            if (!bsy[i]) begin
              // stop bit done, ack the channel and free the slot
              go[i]    <= 1'b0;
              phase[i] <= ph_empty;
            end
          end

          default: begin
            phase[i] <= ph_empty;
          end
        endcase
      end
    end

    // go must only ever request a frame for a loaded slot
    a_go_loaded: assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(go[i]) |-> ($past(full[i]) && full[i])
    );
  end

  // host must address an existing channel
  a_chan_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr |-> (wr_chan < NUM_CHAN)
  );

endmodule

// File: uart_tx/uart_tx_channel.sv
// one 8n1 uart transmitter with the go/bsy level handshake
// raise go with data stable, drop go after bsy falls to return to idle
`timescale 1ns/1ps

module uart_tx_channel #(
  parameter int BIT_TIME = 8  // clk cycles per serial bit
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_bank_pkg::byte_t data,  // must hold while bsy is high
  input  logic                 go,    // level, start request and ack
  output logic                 tx,    // serial line, idle high
  output logic                 bsy    // high for start, data and stop bits
);

  localparam int CNT_W = (BIT_TIME > 1) ? $clog2(BIT_TIME) : 1;
  localparam int IDX_W = $clog2(uart_bank_pkg::DATA_BITS);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BIT_TIME - 1);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(uart_bank_pkg::DATA_BITS - 1);

  uart_bank_pkg::tx_state_e state;
  logic [CNT_W-1:0] bit_cnt;  // counts down the cycles of the current bit
  logic [IDX_W-1:0] bit_idx;  // data bit currently on the line

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= uart_bank_pkg::idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
      bsy     <= 1'b0;
    end else begin
      case (state)
        uart_bank_pkg::idle: begin
          if (go) begin
            // first cycle of the start bit begins right after this edge
            tx      <= 1'b0;
            bsy     <= 1'b1;
            bit_cnt <= CNT_LAST;
            state   <= uart_bank_pkg::start_bit;
          end
        end

        uart_bank_pkg::start_bit: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            tx      <= data[0];  // lsb goes out first
            bit_idx <= '0;
            bit_cnt <= CNT_LAST;
            state   <= uart_bank_pkg::data_bits;
          end
        end

        uart_bank_pkg::data_bits: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            bit_cnt <= CNT_LAST;
            if (bit_idx == IDX_LAST) begin
              tx    <= 1'b1;  // stop bit
              state <= uart_bank_pkg::stop_bit;
            end else begin
              tx      <= data[bit_idx + 1'b1];
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end

        uart_bank_pkg::stop_bit: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            bsy   <= 1'b0;  // last stop cycle just ended
            state <= uart_bank_pkg::wait_go_low;
          end
        end

        uart_bank_pkg::wait_go_low: begin
          // hold off a new frame until the dispatcher acks with go low
          if (!go) begin
            state <= uart_bank_pkg::idle;
          end
        end

        default: begin
          state <= uart_bank_pkg::idle;
        end
      endcase
    end
  end

  // payload comes from the dispatcher slot, it must not move mid-frame
  a_data_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (bsy && $past(bsy)) |-> $stable(data)
  );

  // bsy is a register of its own, keep it in step with the fsm
  a_bsy_state: assert property (
    @(posedge clk) disable iff (!rst_n)
    bsy == (state inside {uart_bank_pkg::start_bit, uart_bank_pkg::data_bits,
                          uart_bank_pkg::stop_bit})
  );

  // line must be released after every frame
  a_tx_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == uart_bank_pkg::idle) |-> tx
  );

endmodule

// File: common/uart_bank_pkg.sv
// shared definitions for the uart transmit bank
// used by the rtl modules through scoped names
package uart_bank_pkg;

  // frame format is fixed 8n1
  localparam int DATA_BITS = 8;

  // payload of one serial frame
  typedef logic [DATA_BITS-1:0] byte_t;

  // transmitter fsm states in frame order
  typedef enum logic [2:0] {
    idle,         // line high until go
    start_bit,    // driving 0 for one bit time
    data_bits,    // lsb first
    stop_bit,     // driving 1 with bsy still high
    wait_go_low   // frame done and waiting for the ack
  } tx_state_e;

endpackage
